//--- display_timing.sv
`timescale 1ns/1ps

module display_timing import frame_pkg::*; (
    input  logic clock,
    input  logic reset,

    output logic hsync,
    output logic vsync,
    output logic active,
    output logic frame_start
);

    h_count_t h_count;
    v_count_t v_count;
    logic     line_end;
    logic     frame_end;

    assign line_end  = (h_count == H_TOTAL - 1'b1);
    assign frame_end = (v_count == V_TOTAL - 1'b1);

    // Pixel and line counters
    always_ff @(posedge clock) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (line_end) begin
                h_count <= '0;
                if (frame_end) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // Decoded from the counters, one clock behind them
    always_ff @(posedge clock) begin
        if (reset) begin
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            active      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hsync       <= (h_count >= H_SYNC_START) && (h_count < H_SYNC_END);
            vsync       <= (v_count >= V_SYNC_START) && (v_count < V_SYNC_END);
            active      <= (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
            frame_start <= (h_count == '0) && (v_count == '0);
        end
    end

endmodule

//--- frame_pkg.sv
package frame_pkg;

    // Widths with a meaning on the SPI side
    typedef logic [7:0]  byte_t;     // Opcodes, operands and responses
    typedef logic [15:0] count_t;    // Operands since the opcode

    // Display pin widths
    typedef logic [3:0] luma_t;
    typedef logic [2:0] chroma_t;

    // Raster counters
    typedef logic [4:0] h_count_t;
    typedef logic [3:0] v_count_t;

    // Horizontal raster, in clocks
    localparam h_count_t H_ACTIVE     = 5'd16;
    localparam h_count_t H_FRONT      = 5'd2;
    localparam h_count_t H_SYNC       = 5'd3;
    localparam h_count_t H_TOTAL      = 5'd24;
    localparam h_count_t H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam h_count_t H_SYNC_END   = H_ACTIVE + H_FRONT + H_SYNC;

    // Vertical raster, in lines
    localparam v_count_t V_ACTIVE     = 4'd8;
    localparam v_count_t V_FRONT      = 4'd1;
    localparam v_count_t V_SYNC       = 4'd2;
    localparam v_count_t V_TOTAL      = 4'd12;
    localparam v_count_t V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam v_count_t V_SYNC_END   = V_ACTIVE + V_FRONT + V_SYNC;

    // Opcodes
    localparam byte_t OP_CHIP_ID     = 8'hDB;
    localparam byte_t CHIP_ID_VALUE  = 8'h81;
    localparam byte_t OP_SET_COLOR   = 8'h10;
    localparam byte_t OP_FRAME_COUNT = 8'h11;

    // Which byte of a transaction is on the wire
    typedef enum logic [1:0] {
        IDLE_ST,
        OPCODE_ST,
        OPERAND_ST
    } spi_state_t;

endpackage

//--- graphics.sv
`timescale 1ns/1ps

module graphics import frame_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  byte_t   opcode,
    input  logic    opcode_valid,
    input  byte_t   operand,
    input  logic    operand_valid,
    input  count_t  operand_count,
    output byte_t   response,
    output logic    response_valid,

    output logic    display_hsync,
    output logic    display_vsync,
    output luma_t   display_y,
    output chroma_t display_cb,
    output chroma_t display_cr
);

    logic    hsync;
    logic    vsync;
    logic    active;
    logic    frame_start;

    byte_t   last_opcode;
    logic    colour_write;
    logic    count_read;

    luma_t   staged_y;
    chroma_t staged_cb;
    luma_t   pending_y;
    chroma_t pending_cb;
    chroma_t pending_cr;
    luma_t   live_y;
    chroma_t live_cb;
    chroma_t live_cr;
    luma_t   frame_y;
    chroma_t frame_cb;
    chroma_t frame_cr;

    byte_t   frame_count;

    display_timing display_timing (
        .clock(clock),
        .reset(reset),
        .hsync(hsync),
        .vsync(vsync),
        .active(active),
        .frame_start(frame_start)
    );

    assign colour_write = operand_valid && (last_opcode == OP_SET_COLOR);
    assign count_read   = opcode_valid && (opcode == OP_FRAME_COUNT);

    // First two bytes wait here until the third arrives
    always_ff @(posedge clock) begin
        if (colour_write && operand_count == 16'd0) begin
            staged_y <= luma_t'(operand);
        end
        if (colour_write && operand_count == 16'd1) begin
            staged_cb <= chroma_t'(operand);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_opcode <= '0;
            pending_y   <= '0;
            pending_cb  <= '0;
            pending_cr  <= '0;
            live_y      <= '0;
            live_cb     <= '0;
            live_cr     <= '0;
        end else begin
            if (opcode_valid) begin
                last_opcode <= opcode;
            end
            if (colour_write && operand_count == 16'd2) begin
                pending_y  <= staged_y;
                pending_cb <= staged_cb;
                pending_cr <= chroma_t'(operand);
            end
            if (frame_start) begin  // Whole frames only
                live_y  <= pending_y;
                live_cb <= pending_cb;
                live_cr <= pending_cr;
            end
        end
    end

    // First pixel of a frame already takes the new colour
    assign frame_y  = frame_start ? pending_y : live_y;
    assign frame_cb = frame_start ? pending_cb : live_cb;
    assign frame_cr = frame_start ? pending_cr : live_cr;

    always_ff @(posedge clock) begin
        if (reset) begin
            display_hsync <= 1'b0;
            display_vsync <= 1'b0;
            display_y     <= '0;
            display_cb    <= '0;
            display_cr    <= '0;
        end else begin
            display_hsync <= hsync;     // Kept in line with the pixels
            display_vsync <= vsync;
            display_y     <= active ? frame_y : '0;
            display_cb    <= active ? frame_cb : '0;
            display_cr    <= active ? frame_cr : '0;
        end
    end

    // Frame counter and its read back
    always_ff @(posedge clock) begin
        if (reset) begin
            frame_count    <= '0;
            response_valid <= 1'b0;
        end else begin
            response_valid <= count_read;
            if (frame_start) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (count_read) begin
            response <= frame_count;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module top_tb -o sim_top_tb
./obj_dir/sim_top_tb | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- spi_peripheral.sv
`timescale 1ns/1ps

module spi_peripheral import frame_pkg::*; (
    input  logic   clock,
    input  logic   reset,

    input  logic   spi_select,
    input  logic   spi_clock,
    input  logic   spi_data_in,
    output logic   spi_data_out,

    output byte_t  opcode,
    output logic   opcode_valid,
    output byte_t  operand,
    output logic   operand_valid,
    output count_t operand_count,

    input  byte_t  response_1,
    input  logic   response_1_valid,
    input  byte_t  response_2,
    input  logic   response_2_valid
);

    // Pin synchronizers
    logic select_meta;
    logic select_sync;
    logic clock_meta;
    logic clock_sync;
    logic clock_last;
    logic data_meta;
    logic data_sync;

    logic sclk_rise;
    logic sclk_fall;
    logic byte_done;
    logic opcode_done;
    logic operand_done;

    spi_state_t state;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;           // Bits received so far
    byte_t      rx_byte;
    byte_t      tx_shift;
    count_t     next_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            select_meta <= 1'b1;    // Deselected
            select_sync <= 1'b1;
            clock_meta  <= 1'b0;
            clock_sync  <= 1'b0;
            clock_last  <= 1'b0;
            data_meta   <= 1'b0;
            data_sync   <= 1'b0;
        end else begin
            select_meta <= spi_select;
            select_sync <= select_meta;
            clock_meta  <= spi_clock;
            clock_sync  <= clock_meta;
            clock_last  <= clock_sync;
            data_meta   <= spi_data_in;
            data_sync   <= data_meta;
        end
    end

    // Edges one cycle after the synchronizer
    assign sclk_rise = clock_sync & ~clock_last;
    assign sclk_fall = ~clock_sync & clock_last;

    assign byte_done    = ~select_sync & sclk_rise & (bit_count == 3'd7);
    assign opcode_done  = byte_done & (state != OPERAND_ST);
    assign operand_done = byte_done & (state == OPERAND_ST);
    assign rx_byte      = {rx_shift, data_sync};

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= IDLE_ST;
            bit_count     <= '0;
            next_count    <= '0;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
        end else begin
            opcode_valid  <= opcode_done;
            operand_valid <= operand_done;

            if (select_sync) begin
                state     <= IDLE_ST;   // Deselect drops any partial byte
                bit_count <= '0;
            end else begin
                if (state == IDLE_ST) begin
                    state <= OPCODE_ST;
                end
                if (sclk_rise) begin
                    bit_count <= bit_count + 1'b1;
                end
                if (opcode_done) begin
                    state      <= OPERAND_ST;
                    next_count <= '0;
                end
                if (operand_done) begin
                    next_count <= next_count + 1'b1;
                end
            end
        end
    end

    // Byte payload
    always_ff @(posedge clock) begin
        if (~select_sync && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], data_sync};
        end
        if (opcode_done) begin
            opcode <= rx_byte;
        end
        if (operand_done) begin
            operand       <= rx_byte;
            operand_count <= next_count;
        end
    end

    // Transmit side, MSB sits on the pin as soon as it is loaded
    always_ff @(posedge clock) begin
        if (reset) begin
            tx_shift <= '0;
        end else if (select_sync) begin
            tx_shift <= '0;
        end else if (response_1_valid) begin
            tx_shift <= response_1;
        end else if (response_2_valid) begin
            tx_shift <= response_2;
        end else if (byte_done) begin
            tx_shift <= '0;         // Unclaimed bytes read as zero
        end else if (sclk_fall && bit_count != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_data_out = tx_shift[7];

endmodule

//--- spi_register.sv
`timescale 1ns/1ps

module spi_register import frame_pkg::*; #(
    parameter byte_t REGISTER_ADDRESS = 8'h00,
    parameter byte_t REGISTER_VALUE   = 8'h00
) (
    input  logic  clock,
    input  logic  reset,

    input  byte_t opcode,
    input  logic  opcode_valid,
    output byte_t response,
    output logic  response_valid
);

    logic hit;

    assign hit = opcode_valid && (opcode == REGISTER_ADDRESS);

    always_ff @(posedge clock) begin
        if (reset) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= hit;  // One clock after the opcode
        end
    end

    always_ff @(posedge clock) begin
        if (hit) begin
            response <= REGISTER_VALUE;
        end
    end

endmodule

//--- top.sv
`timescale 1ns/1ps

module top import frame_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  logic    spi_select,
    input  logic    spi_clock,
    input  logic    spi_data_in,
    output logic    spi_data_out,

    output logic    display_hsync,
    output logic    display_vsync,
    output luma_t   display_y,
    output chroma_t display_cb,
    output chroma_t display_cr
);

    // Decoded SPI traffic
    byte_t  opcode;
    logic   opcode_valid;
    byte_t  operand;
    logic   operand_valid;
    count_t operand_count;

    byte_t  response_1;         // Chip ID
    logic   response_1_valid;
    byte_t  response_2;         // Graphics
    logic   response_2_valid;

    spi_peripheral spi_peripheral (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response_1(response_1),
        .response_1_valid(response_1_valid),
        .response_2(response_2),
        .response_2_valid(response_2_valid)
    );

    spi_register #(
        .REGISTER_ADDRESS(OP_CHIP_ID),
        .REGISTER_VALUE(CHIP_ID_VALUE)
    ) chip_id (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .response(response_1),
        .response_valid(response_1_valid)
    );

    graphics graphics (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response(response_2),
        .response_valid(response_2_valid),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

endmodule

//--- top_sva.sv
`timescale 1ns/1ps

module top_sva import frame_pkg::*; (
    input logic clock,
    input logic reset,
    input logic select_sync,
    input logic opcode_valid,
    input logic operand_valid
);

    // A byte is either an opcode or an operand
    valid_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(opcode_valid && operand_valid))
        else $error("opcode_valid and operand_valid high together");

    opcode_pulse: assert property (@(posedge clock) disable iff (reset)
        opcode_valid |=> !opcode_valid)
        else $error("opcode_valid held longer than one cycle");

    operand_pulse: assert property (@(posedge clock) disable iff (reset)
        operand_valid |=> !operand_valid)
        else $error("operand_valid held longer than one cycle");

    // Decode pulses trail the synchronized select by one flop
    no_valid_deselected: assert property (@(posedge clock) disable iff (reset)
        select_sync |=> !(opcode_valid || operand_valid))
        else $error("decode pulse while the peripheral is deselected");

endmodule

bind spi_peripheral top_sva sva (
    .clock(clock),
    .reset(reset),
    .select_sync(select_sync),
    .opcode_valid(opcode_valid),
    .operand_valid(operand_valid)
);

//--- top_tb.sv
`timescale 1ns/1ps

module top_tb import frame_pkg::*; ();

    localparam int HALF_PERIOD    = 4;     // Clocks per SCLK half period
    localparam int GAP_CLOCKS     = 8;     // Deselected time between transactions
    localparam int TRANSACTIONS   = 40;
    localparam int H_ACT          = int'(H_ACTIVE);
    localparam int H_FP           = int'(H_FRONT);
    localparam int H_SYN          = int'(H_SYNC);
    localparam int H_TOT          = int'(H_TOTAL);
    localparam int V_ACT          = int'(V_ACTIVE);
    localparam int V_FP           = int'(V_FRONT);
    localparam int V_SYN          = int'(V_SYNC);
    localparam int V_TOT          = int'(V_TOTAL);
    localparam int FRAME_CLOCKS   = H_TOT * V_TOT;
    localparam int TIMEOUT_CYCLES = TRANSACTIONS * 400 + 20 * FRAME_CLOCKS;

    logic    clock = 1'b0;
    logic    reset;
    logic    spi_select;
    logic    spi_clock;
    logic    spi_data_in;
    logic    spi_data_out;
    logic    display_hsync;
    logic    display_vsync;
    luma_t   display_y;
    chroma_t display_cb;
    chroma_t display_cr;

    int      seed = 32'ha8e1;
    byte_t   send_q[$];
    byte_t   recv_q[$];
    int      host_checks = 0;
    int      host_errors = 0;
    int      mon_checks  = 0;
    int      mon_errors  = 0;
    int      cycle_count = 0;
    int      n;
    int      frames_at_opcode;

    // Colour and frame model
    luma_t   pending_y  = '0;
    chroma_t pending_cb = '0;
    chroma_t pending_cr = '0;
    luma_t   live_y     = '0;
    chroma_t live_cb    = '0;
    chroma_t live_cr    = '0;
    int      model_frames = 0;

    // Raster monitor state
    int      edges;
    int      pos;
    int      h;
    int      v;
    logic    exp_active;
    logic    exp_hsync;
    logic    exp_vsync;
    luma_t   exp_y;
    chroma_t exp_cb;
    chroma_t exp_cr;
    logic    hsync_prev = 1'b0;
    logic    hsync_seen = 1'b0;
    int      hsync_width = 0;
    int      hsync_period = 0;
    logic    vsync_prev = 1'b0;
    logic    vsync_seen = 1'b0;
    int      vsync_width = 0;
    int      vsync_period = 0;

    top dut (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

    always #20 clock = ~clock;

    task automatic wait_clocks(input int count);
        repeat (count) @(posedge clock);
        #1;
    endtask

    function automatic int random_below(input int limit);
        int value;
        value = $random(seed) & 32'h7fff_ffff;
        return value % limit;
    endfunction

    task automatic check_byte(input string what, input byte_t got, input byte_t expected);
        host_checks++;
        assert (got === expected) else begin
            host_errors++;
            $display("ERR %0t %s read %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Host side of one transaction, MSB first, stops early after bit_limit bits
    task automatic spi_transaction(input int bit_limit);
        byte_t rx;
        int    sent;
        int    b;
        int    i;
        recv_q.delete();
        rx = '0;
        sent = 0;
        spi_select = 1'b0;
        wait_clocks(HALF_PERIOD);
        for (b = 0; b < send_q.size() && sent < bit_limit; b++) begin
            for (i = 7; i >= 0 && sent < bit_limit; i--) begin
                spi_clock = 1'b0;
                spi_data_in = send_q[b][i];
                wait_clocks(HALF_PERIOD);
                rx = {rx[6:0], spi_data_out};   // Sampled just before the rise
                spi_clock = 1'b1;
                if (b == 0 && i == 0) begin
                    frames_at_opcode = model_frames;
                end
                wait_clocks(HALF_PERIOD);
                // Third operand of a colour write has committed by now
                if (b == 3 && i == 0 && send_q[0] == OP_SET_COLOR) begin
                    pending_y  = luma_t'(send_q[1]);
                    pending_cb = chroma_t'(send_q[2]);
                    pending_cr = chroma_t'(send_q[3]);
                end
                sent++;
            end
            if (i < 0) begin
                recv_q.push_back(rx);
            end
        end
        spi_clock = 1'b0;
        wait_clocks(HALF_PERIOD);
        spi_select = 1'b1;
        wait_clocks(GAP_CLOCKS);
    endtask

    task automatic run_chip_id_read();
        send_q = '{OP_CHIP_ID, byte_t'($random(seed))};
        spi_transaction(16);
        check_byte("chip ID opcode byte", recv_q[0], 8'h00);
        check_byte("chip ID", recv_q[1], CHIP_ID_VALUE);
    endtask

    task automatic run_unknown_read();
        byte_t op;
        do begin
            op = byte_t'($random(seed));
        end while (op == OP_CHIP_ID || op == OP_SET_COLOR || op == OP_FRAME_COUNT);
        send_q = '{op, 8'h00};
        spi_transaction(16);
        check_byte("unknown opcode", recv_q[1], 8'h00);
    endtask

    task automatic run_colour_write(input int extras);
        int k;
        send_q = '{OP_SET_COLOR};
        for (k = 0; k < 3 + extras; k++) begin
            send_q.push_back(byte_t'($random(seed)));
        end
        spi_transaction(8 * send_q.size());
    endtask

    task automatic run_frame_count_read();
        byte_t got;
        send_q = '{OP_FRAME_COUNT, 8'h00};
        spi_transaction(16);
        got = recv_q[1];
        host_checks++;
        assert (got == byte_t'(frames_at_opcode) || got == byte_t'(frames_at_opcode + 1)) else begin
            host_errors++;
            $display("ERR %0t frame count read %0d, expected %0d or %0d",
                     $time, got, frames_at_opcode, frames_at_opcode + 1);
        end
    endtask

    // Cut off mid-byte, then a clean chip ID read
    task automatic run_aborted_then_id();
        send_q = '{byte_t'($random(seed)), byte_t'($random(seed))};
        spi_transaction(1 + random_below(15));
        run_chip_id_read();
    endtask

    initial begin
        reset = 1'b1;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data_in = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        wait_clocks(GAP_CLOCKS);

        run_chip_id_read();
        run_unknown_read();
        run_colour_write(0);
        run_frame_count_read();
        run_aborted_then_id();
        run_colour_write(2);        // Extra operands must not touch the colour
        for (n = 6; n < TRANSACTIONS; n++) begin
            case (random_below(5))
                0: run_chip_id_read();
                1: run_unknown_read();
                2: run_colour_write(random_below(3));
                3: run_frame_count_read();
                default: run_aborted_then_id();
            endcase
        end
        wait_clocks(2 * FRAME_CLOCKS);  // Last colour reaches the screen

        $display("Checks %0d, errors %0d", host_checks + mon_checks, host_errors + mon_errors);
        if (host_errors + mon_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles, the test did not finish", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

    // Display outputs show counter position edges - 2
    always @(negedge clock) begin
        if (reset) begin
            edges = 0;
        end else begin
            pos = edges - 2;
            exp_active = 1'b0;
            exp_hsync = 1'b0;
            exp_vsync = 1'b0;
            if (pos >= 0) begin
                h = pos % H_TOT;
                v = (pos / H_TOT) % V_TOT;
                exp_active = (h < H_ACT) && (v < V_ACT);
                exp_hsync = (h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SYN);
                exp_vsync = (v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SYN);
            end
            exp_y = '0;
            exp_cb = '0;
            exp_cr = '0;
            if (exp_active) begin
                exp_y = live_y;
                exp_cb = live_cb;
                exp_cr = live_cr;
            end

            mon_checks++;
            assert (display_hsync === exp_hsync && display_vsync === exp_vsync) else begin
                mon_errors++;
                $display("ERR %0t sync h%b v%b, expected h%b v%b at position %0d",
                         $time, display_hsync, display_vsync, exp_hsync, exp_vsync, pos);
            end
            mon_checks++;
            assert (display_y === exp_y && display_cb === exp_cb && display_cr === exp_cr)
            else begin
                mon_errors++;
                $display("ERR %0t pixel %h %h %h, expected %h %h %h at position %0d",
                         $time, display_y, display_cb, display_cr, exp_y, exp_cb, exp_cr, pos);
            end

            // Pulse widths and periods measured at the pins
            if (display_hsync && !hsync_prev) begin
                if (hsync_seen) begin
                    mon_checks++;
                    assert (hsync_period == H_TOT) else begin
                        mon_errors++;
                        $display("ERR %0t hsync period %0d", $time, hsync_period);
                    end
                end
                hsync_seen = 1'b1;
                hsync_period = 0;
            end
            hsync_period++;
            if (display_hsync) begin
                hsync_width++;
            end else begin
                if (hsync_prev) begin
                    mon_checks++;
                    assert (hsync_width == H_SYN) else begin
                        mon_errors++;
                        $display("ERR %0t hsync width %0d", $time, hsync_width);
                    end
                end
                hsync_width = 0;
            end
            hsync_prev = display_hsync;

            if (display_vsync && !vsync_prev) begin
                if (vsync_seen) begin
                    mon_checks++;
                    assert (vsync_period == FRAME_CLOCKS) else begin
                        mon_errors++;
                        $display("ERR %0t vsync period %0d", $time, vsync_period);
                    end
                end
                vsync_seen = 1'b1;
                vsync_period = 0;
            end
            vsync_period++;
            if (display_vsync) begin
                vsync_width++;
            end else begin
                if (vsync_prev) begin
                    mon_checks++;
                    assert (vsync_width == V_SYN * H_TOT) else begin
                        mon_errors++;
                        $display("ERR %0t vsync width %0d", $time, vsync_width);
                    end
                end
                vsync_width = 0;
            end
            vsync_prev = display_vsync;

            if (pos >= 0 && pos % FRAME_CLOCKS == 0) begin
                model_frames++;
            end
            // Next edge shows a frame's first pixel
            if ((pos + 1) % FRAME_CLOCKS == 0) begin
                live_y = pending_y;
                live_cb = pending_cb;
                live_cr = pending_cr;
            end
            edges++;
        end
    end

endmodule

//--- vlog.f
frame_pkg.sv
spi_peripheral.sv
spi_register.sv
display_timing.sv
graphics.sv
top.sv
top_sva.sv
top_tb.sv
